//--- files.f
+incdir+verilog
+incdir+verif
verilog/rx_pkg.sv
verilog/comma_align.sv
verilog/symbol_decoder.sv
verilog/word_packer.sv
verilog/word_fifo.sv
verilog/rx_axil_regs.sv
verilog/rx_top.sv
verif/tb_rx.sv

//--- run.sh
#!/usr/bin/env bash
# build the receiver testbench with Verilator, run it, pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rx -f files.f

out=$(./obj_dir/Vtb_rx)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

//--- verif/enc_8b10b_ref.svh
// 8b/10b encoder and expected word model, included inside the testbench module
// K28.5 is the only control symbol sent, the bad symbol is all zeros
// the word model assumes reads happen only after the line is flushed
`ifndef ENC_8B10B_REF_SVH
`define ENC_8B10B_REF_SVH

localparam logic [1:0] SYM_DATA = 2'd0;
localparam logic [1:0] SYM_K285 = 2'd1;
localparam logic [1:0] SYM_BAD  = 2'd2;

// 5b/6b codes abcdei for rd-, index is EDCBA
localparam logic [5:0] ENC6 [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b codes fghj for rd-, primary D.x.7
localparam logic [3:0] ENC4 [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

logic [23:0] exp_q [$];     // words expected in the FIFO, oldest first
logic [7:0]  part [3];
int          part_idx = 0;
logic [7:0]  exp_err  = 8'd0;
logic [7:0]  exp_lost = 8'd0;

task automatic encode_symbol(input logic [1:0] kind, input logic [7:0] d,
                             inout logic rd, output logic [9:0] code);
    logic [5:0] c6;
    logic [3:0] c4;
    logic       rd_mid;
    logic       alt;
    if (kind == SYM_BAD) begin
        code = 10'd0;       // no disparity change on a code error
    end else if (kind == SYM_K285) begin
        code = rd ? 10'b1100000101 : 10'b0011111010;
        rd   = !rd;
    end else begin
        c6 = ENC6[d[4:0]];
        if (rd && ($countones(c6) != 3 || d[4:0] == 5'd7)) begin
            c6 = ~c6;
        end
        rd_mid = ($countones(c6) != 3) ? ($countones(c6) > 3) : rd;
        // alternate D.x.7 avoids a run of five inside the data
        alt = (!rd_mid && (d[4:0] inside {5'd17, 5'd18, 5'd20})) ||
              (rd_mid && (d[4:0] inside {5'd11, 5'd13, 5'd14}));
        c4 = (d[7:5] == 3'd7 && alt) ? 4'b0111 : ENC4[d[7:5]];
        if (rd_mid && ($countones(c4) != 2 || d[7:5] == 3'd3)) begin
            c4 = ~c4;
        end
        rd   = ($countones(c4) != 2) ? ($countones(c4) > 2) : rd_mid;
        code = {c6, c4};
    end
endtask

// packing rule: three data bytes per word, K or bad symbol restarts
task automatic ref_symbol(input logic [1:0] kind, input logic [7:0] d);
    if (kind != SYM_DATA) begin
        part_idx = 0;
        if (kind == SYM_BAD && exp_err != 8'hff) begin
            exp_err = exp_err + 8'd1;
        end
    end else begin
        part[part_idx] = d;
        if (part_idx == 2) begin
            part_idx = 0;
            if (exp_q.size() < `RX_FIFO_DEPTH) begin
                exp_q.push_back({part[0], part[1], part[2]});
            end else if (exp_lost != 8'hff) begin
                exp_lost = exp_lost + 8'd1;     // FIFO full, word dropped
            end
        end else begin
            part_idx = part_idx + 1;
        end
    end
endtask

`endif

//--- verif/tb_rx.sv
// testbench for rx_top, the serial line is fed from a symbol queue
// idle line time is filled with K28.5 so the receiver never sees a dead line
// register reads are only issued after the line has been flushed
`timescale 1ns/1ns
`include "rx_macros.svh"

module tb_rx;

    localparam int         HALF     = 20;
    localparam int         HS_LIMIT = 20;       // cycles allowed for one handshake
    localparam int         N_SYMS   = 120;      // symbols queued by all tests, rounded up
    localparam int         N_ACCESS = 60;       // register accesses, rounded up
    localparam int         WATCHDOG_NS = N_SYMS * 10 * 2 * HALF + N_ACCESS * 20 * 2 * HALF +
                                         16 * 2 * HALF;
    localparam logic [1:0] OKAY     = 2'b00;
    localparam logic [1:0] SLVERR   = 2'b10;

    logic        WCLK;
    logic        RESET_WCLK;
    logic        rx_bit;
    logic [3:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [3:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;

    logic [9:0]  tx_q [$];          // {kind, byte}
    logic        tx_rd = 1'b0;      // encoder running disparity, starts negative
    int          syms_sent = 0;
    logic        rst_done = 1'b0;
    integer      seed = 32'h47fd;
    logic [31:0] exp_data_q [$];
    logic [1:0]  exp_resp_q [$];
    int          n_checks = 0;
    int          n_fail = 0;        // wrong values
    int          n_other = 0;       // handshake and bookkeeping problems

    `include "enc_8b10b_ref.svh"

    rx_top uut (.*);

    initial begin
        WCLK = 1'b0;
        forever #HALF WCLK = ~WCLK;
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired at %0t, run did not finish", $time);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] expected_rdata(input logic [3:0] addr);
        logic [31:0] v;
        v = 32'd0;
        case (addr)
            `RX_ADDR_DATA: begin
                if (exp_q.size() > 0) begin
                    v = {8'd0, exp_q[0]};
                end
            end
            `RX_ADDR_STATUS: begin
                v[0]    = (exp_q.size() == 0);
                v[1]    = (exp_q.size() == `RX_FIFO_DEPTH);
                v[2]    = 1'b1;     // every read follows at least one comma
                v[12:8] = 5'(exp_q.size());
            end
            `RX_ADDR_COUNT: v = {16'd0, exp_lost, exp_err};
            default:        v = 32'd0;
        endcase
        return v;
    endfunction

    function automatic logic [1:0] expected_rresp(input logic [3:0] addr);
        if (addr == `RX_ADDR_DATA || addr == `RX_ADDR_STATUS ||
            addr == `RX_ADDR_COUNT || addr == `RX_ADDR_CTRL) begin
            return OKAY;
        end
        return SLVERR;
    endfunction

    task automatic send_sym(input logic [1:0] kind, input logic [7:0] d);
        tx_q.push_back({kind, d});
        ref_symbol(kind, d);
    endtask

    task automatic send_triples(input int n);
        repeat (3 * n) send_sym(SYM_DATA, 8'($random(seed)));
    endtask

    // returns once the queue is drained and one idle symbol has followed
    task automatic flush_line();
        int start;
        while (tx_q.size() != 0) @(negedge WCLK);
        start = syms_sent;
        while (syms_sent < start + 2) @(negedge WCLK);
    endtask

    task automatic axi_read(input logic [3:0] addr, input int stall);
        int n;
        exp_data_q.push_back(expected_rdata(addr));
        exp_resp_q.push_back(expected_rresp(addr));
        if (addr == `RX_ADDR_DATA && exp_q.size() > 0) begin
            exp_q.delete(0);        // popped by this read
        end
        @(negedge WCLK);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = (stall == 0);
        n = 0;
        #(HALF - 1);
        while (!s_arready && n < HS_LIMIT) begin
            @(negedge WCLK);
            #(HALF - 1);
            n++;
        end
        if (!s_arready) begin
            $display("read of address %h got no ARREADY at %0t", addr, $time);
            n_other++;
        end
        @(negedge WCLK);
        s_arvalid = 1'b0;
        repeat (stall) @(negedge WCLK);
        s_rready = 1'b1;
        n = 0;
        #(HALF - 1);
        while (!s_rvalid && n < HS_LIMIT) begin
            @(negedge WCLK);
            #(HALF - 1);
            n++;
        end
        if (!s_rvalid) begin
            $display("read of address %h got no response at %0t", addr, $time);
            n_other++;
        end
        @(negedge WCLK);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int n;
        @(negedge WCLK);
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;
        n = 0;
        #(HALF - 1);
        while (!(s_awready && s_wready) && n < HS_LIMIT) begin
            @(negedge WCLK);
            #(HALF - 1);
            n++;
        end
        if (!s_awready || !s_wready) begin
            $display("write to address %h got no AWREADY or WREADY at %0t", addr, $time);
            n_other++;
        end
        @(negedge WCLK);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        #(HALF - 1);
        if (!s_bvalid) begin
            $display("write to address %h got no response at %0t", addr, $time);
            n_other++;
        end else if (s_bresp !== exp_resp) begin
            $display("Fail at %0t: s_bresp expected %b got %b", $time, exp_resp, s_bresp);
            n_fail++;
        end
        n_checks++;
        if (addr == `RX_ADDR_CTRL && data[0]) begin
            exp_err  = 8'd0;
            exp_lost = 8'd0;
        end
        @(negedge WCLK);
    endtask

    // checks each read response just before the clock edge that takes it
    initial begin : compare_reads
        logic [31:0] held;
        logic        held_ok;
        logic [31:0] exp_d;
        logic [1:0]  exp_r;
        held_ok = 1'b0;
        forever begin
            @(negedge WCLK);
            #(HALF - 1);
            if (s_rvalid && s_rready) begin
                if (exp_data_q.size() == 0) begin
                    $display("read response at %0t with no read outstanding", $time);
                    n_other++;
                end else begin
                    exp_d = exp_data_q.pop_front();
                    exp_r = exp_resp_q.pop_front();
                    if (s_rresp !== exp_r) begin
                        $display("Fail at %0t: s_rresp expected %b got %b", $time, exp_r, s_rresp);
                        n_fail++;
                    end
                    if (exp_r == OKAY && s_rdata !== exp_d) begin
                        $display("Fail at %0t: s_rdata expected %h got %h", $time, exp_d, s_rdata);
                        n_fail++;
                    end
                    n_checks++;
                end
                held_ok = 1'b0;
            end else if (s_rvalid) begin
                if (held_ok && s_rdata !== held) begin
                    $display("Fail at %0t: s_rdata expected %h got %h", $time, held, s_rdata);
                    n_fail++;
                end
                held    = s_rdata;      // stalled response must not move
                held_ok = 1'b1;
            end
        end
    end

    initial begin : serializer
        logic [9:0] item;
        logic [9:0] code;
        int         i;
        rx_bit = 1'b0;
        while (!rst_done) @(negedge WCLK);
        forever begin
            if (tx_q.size() > 0) begin
                item = tx_q.pop_front();
            end else begin
                item = {SYM_K285, 8'd0};    // idle fill
            end
            encode_symbol(item[9:8], item[7:0], tx_rd, code);
            for (i = 9; i >= 0; i--) begin
                rx_bit = code[i];           // bit a first
                @(negedge WCLK);
            end
            syms_sent++;
        end
    end

    initial begin : main
        s_awaddr   = 4'd0;
        s_awvalid  = 1'b0;
        s_wdata    = 32'd0;
        s_wvalid   = 1'b0;
        s_bready   = 1'b1;
        s_araddr   = 4'd0;
        s_arvalid  = 1'b0;
        s_rready   = 1'b1;
        RESET_WCLK = 1'b1;
        repeat (16) @(posedge WCLK);
        @(negedge WCLK);
        RESET_WCLK = 1'b0;
        rst_done   = 1'b1;

        // lock, then words come out in order
        send_sym(SYM_K285, 8'd0);
        send_triples(6);
        flush_line();
        axi_read(`RX_ADDR_STATUS, 0);
        while (exp_q.size() > 0) axi_read(`RX_ADDR_DATA, 0);
        axi_read(`RX_ADDR_STATUS, 0);

        // K28.5 after one and after two bytes drops the partial word
        send_sym(SYM_DATA, 8'($random(seed)));
        send_sym(SYM_K285, 8'd0);
        send_sym(SYM_DATA, 8'($random(seed)));
        send_sym(SYM_DATA, 8'($random(seed)));
        send_sym(SYM_K285, 8'd0);
        send_triples(1);
        flush_line();
        axi_read(`RX_ADDR_STATUS, 0);
        axi_read(`RX_ADDR_DATA, 0);
        axi_read(`RX_ADDR_STATUS, 0);

        // bad symbol, D.x.1 before it so no comma forms with the zeros
        send_sym(SYM_DATA, 8'($random(seed)));
        send_sym(SYM_DATA, {3'b001, 5'($random(seed))});
        send_sym(SYM_BAD, 8'd0);
        send_triples(1);
        flush_line();
        axi_read(`RX_ADDR_COUNT, 0);
        axi_read(`RX_ADDR_DATA, 0);
        axi_write(`RX_ADDR_CTRL, 32'd1, OKAY);
        axi_read(`RX_ADDR_COUNT, 0);

        // overflow, four words lost
        send_triples(20);
        flush_line();
        axi_read(`RX_ADDR_STATUS, 0);
        axi_read(`RX_ADDR_COUNT, 0);
        while (exp_q.size() > 0) axi_read(`RX_ADDR_DATA, 0);
        axi_read(`RX_ADDR_STATUS, 0);

        // empty read and error responses
        axi_read(`RX_ADDR_DATA, 0);
        axi_read(4'h2, 0);
        axi_read(4'hD, 0);
        axi_write(4'h6, 32'd1, SLVERR);
        axi_write(`RX_ADDR_DATA, 32'd1, SLVERR);
        axi_write(`RX_ADDR_CTRL, 32'd0, OKAY);     // bit 0 clear, counters stay
        axi_read(`RX_ADDR_COUNT, 0);
        axi_write(`RX_ADDR_CTRL, 32'd1, OKAY);     // lost count goes back to zero
        axi_read(`RX_ADDR_COUNT, 0);

        // stalled read responses
        send_triples(2);
        flush_line();
        axi_read(`RX_ADDR_DATA, 5);
        axi_read(`RX_ADDR_DATA, 3);
        axi_read(`RX_ADDR_STATUS, 0);

        repeat (4) @(negedge WCLK);
        if (exp_data_q.size() != 0) begin
            $display("%0d read responses never arrived", exp_data_q.size());
            n_other++;
        end
        $display("checks %0d, value errors %0d, other errors %0d", n_checks, n_fail, n_other);
        if (n_fail == 0 && n_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/comma_align.sv
// serial to symbol aligner, one bit per WCLK
// alignment is taken from K28.5 only, other commas are not searched for
// lock never drops once set, only reset clears it
`timescale 1ns/1ns
`include "rx_macros.svh"

module comma_align (
    input  logic            WCLK,
    input  logic            RESET_WCLK,
    input  logic            rx_bit,
    output rx_pkg::rx_sym_t sym,
    output logic            locked
);

    logic [9:0] win;        // oldest bit in win[9]
    logic [3:0] bit_cnt;    // bits since last boundary
    logic       comma_hit;
    logic       boundary;
    logic       emit;

    // comma sits in the upper 7 bits once a full symbol is in the window
    assign comma_hit = (win[9:3] == `RX_COMMA_NEG) || (win[9:3] == `RX_COMMA_POS);
    assign boundary  = locked && (bit_cnt == 4'd9);
    // a comma off the boundary re-aligns, on the boundary it is a normal symbol
    assign emit      = boundary || comma_hit;

    always_ff @(posedge WCLK) begin
        win <= {win[8:0], rx_bit};
    end

    always_ff @(posedge WCLK) begin
        if (emit) begin
            sym.code <= win;
        end
        if (RESET_WCLK) begin
            sym.valid <= 1'b0;
            locked    <= 1'b0;
            bit_cnt   <= 4'd0;
        end else begin
            sym.valid <= emit;
            if (comma_hit) begin
                locked <= 1'b1;
            end
            if (emit) begin
                bit_cnt <= 4'd0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;   // free running until lock
            end
        end
    end

    // symbols are at least 10 bits apart, a back to back pair means a false comma
    a_sym_spacing: assert property (
        @(posedge WCLK) disable iff (RESET_WCLK)
        sym.valid |=> !sym.valid
    );

endmodule

//--- verilog/rx_axil_regs.sv
// AXI4-Lite slave, one outstanding read and one outstanding write
// WSTRB is not supported, writes act on the full word
// unmapped addresses and writes other than CTRL answer SLVERR
`timescale 1ns/1ns
`include "rx_macros.svh"

module rx_axil_regs (
    input  logic                   WCLK,
    input  logic                   RESET_WCLK,
    input  logic [`RX_AXIL_AW-1:0] s_awaddr,
    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  logic [31:0]            s_wdata,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    output logic [1:0]             s_bresp,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    input  logic [`RX_AXIL_AW-1:0] s_araddr,
    input  logic                   s_arvalid,
    output logic                   s_arready,
    output logic [31:0]            s_rdata,
    output logic [1:0]             s_rresp,
    output logic                   s_rvalid,
    input  logic                   s_rready,
    input  rx_pkg::rx_word_t       fifo_data,
    input  rx_pkg::rx_stat_t       stat,
    output logic                   pop,
    output logic                   clear
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        ar_hs;
    logic        w_hs;
    logic        w_ctrl;
    logic [31:0] rd_mux;
    logic        rd_err;

    assign s_arready = !s_rvalid;
    assign ar_hs     = s_arvalid && s_arready;
    assign pop       = ar_hs && (s_araddr == `RX_ADDR_DATA) && !stat.empty;

    // address and data are taken together
    assign s_awready = s_awvalid && s_wvalid && !s_bvalid;
    assign s_wready  = s_awready;
    assign w_hs      = s_awready;
    assign w_ctrl    = (s_awaddr == `RX_ADDR_CTRL);

    always_comb begin
        rd_mux = 32'd0;
        rd_err = 1'b0;
        case (s_araddr)
            `RX_ADDR_DATA:   rd_mux = stat.empty ? 32'd0 : {8'd0, fifo_data};
            `RX_ADDR_STATUS: rd_mux = {19'd0, stat.count, 5'd0, stat.locked, stat.full,
                                       stat.empty};
            `RX_ADDR_COUNT:  rd_mux = {16'd0, stat.lost_cnt, stat.dec_err_cnt};
            `RX_ADDR_CTRL:   rd_mux = 32'd0;   // write only, reads zero
            default:         rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge WCLK) begin
        if (ar_hs) begin
            s_rdata <= rd_mux;
            s_rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
        if (w_hs) begin
            s_bresp <= w_ctrl ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            s_rvalid <= 1'b0;
            s_bvalid <= 1'b0;
            clear    <= 1'b0;
        end else begin
            if (ar_hs) begin
                s_rvalid <= 1'b1;
            end else if (s_rready) begin
                s_rvalid <= 1'b0;
            end
            if (w_hs) begin
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
            clear <= w_hs && w_ctrl && s_wdata[0];   // single cycle pulse
        end
    end

    // a stalled read must not change under the host, the popped word is gone
    a_rdata_hold: assert property (
        @(posedge WCLK) disable iff (RESET_WCLK)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata)
    );

endmodule

//--- verilog/rx_macros.svh
// constants shared by the receiver RTL
// comma prefixes are bits abcdeif with the first received bit in the msb
// register offsets assume 32-bit aligned accesses
`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

`define RX_FIFO_DEPTH   16
`define RX_COMMA_NEG    7'b0011111  // K28.5 sent with rd-
`define RX_COMMA_POS    7'b1100000  // K28.5 sent with rd+
`define RX_ADDR_DATA    4'h0
`define RX_ADDR_STATUS  4'h4
`define RX_ADDR_COUNT   4'h8
`define RX_ADDR_CTRL    4'hC
`define RX_AXIL_AW      4

`endif

//--- verilog/rx_pkg.sv
// types passed along the receive chain and to the register slave
// all structs are packed, msb first as declared
package rx_pkg;

    // aligned symbol, code[9] is bit a, code[0] is bit j
    typedef struct packed {
        logic       valid;
        logic [9:0] code;
    } rx_sym_t;

    // decoded symbol
    typedef struct packed {
        logic       valid;
        logic       k;      // control symbol
        logic       err;    // code or disparity error
        logic [7:0] data;   // HGFEDCBA
    } rx_byte_t;

    // first received byte in b0
    typedef struct packed {
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
    } rx_word_t;

    typedef struct packed {
        logic [7:0] dec_err_cnt;
        logic [7:0] lost_cnt;
        logic       locked;
        logic       empty;
        logic       full;
        logic [4:0] count;
    } rx_stat_t;

endpackage

//--- verilog/rx_top.sv
// serial 8b/10b receiver with AXI4-Lite readout, single clock domain
// rx_bit must be synchronous to WCLK, one bit per cycle
`timescale 1ns/1ns
`include "rx_macros.svh"

module rx_top (
    input  logic                   WCLK,
    input  logic                   RESET_WCLK,
    input  logic                   rx_bit,
    input  logic [`RX_AXIL_AW-1:0] s_awaddr,
    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  logic [31:0]            s_wdata,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    output logic [1:0]             s_bresp,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    input  logic [`RX_AXIL_AW-1:0] s_araddr,
    input  logic                   s_arvalid,
    output logic                   s_arready,
    output logic [31:0]            s_rdata,
    output logic [1:0]             s_rresp,
    output logic                   s_rvalid,
    input  logic                   s_rready
);
    import rx_pkg::*;

    rx_sym_t    sym;
    rx_byte_t   dec;
    rx_word_t   push_word;
    rx_word_t   fifo_data;
    rx_stat_t   stat;
    logic       push;
    logic       pop;
    logic       clear;

    comma_align u_align (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK), .rx_bit(rx_bit),
        .sym(sym), .locked(stat.locked)
    );

    symbol_decoder u_dec (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK), .sym(sym), .dec(dec)
    );

    word_packer u_pack (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK), .dec(dec), .fifo_full(stat.full),
        .clear(clear), .push(push), .word(push_word),
        .dec_err_cnt(stat.dec_err_cnt), .lost_cnt(stat.lost_cnt)
    );

    word_fifo u_fifo (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK), .push(push), .wdata(push_word),
        .pop(pop), .rdata(fifo_data), .empty(stat.empty), .full(stat.full),
        .count(stat.count)
    );

    rx_axil_regs u_regs (
        .WCLK(WCLK), .RESET_WCLK(RESET_WCLK),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .fifo_data(fifo_data), .stat(stat), .pop(pop), .clear(clear)
    );

endmodule

//--- verilog/symbol_decoder.sv
// 8b/10b decoder with running disparity, one cycle latency
// running disparity starts negative after reset
// K28.y and K23/27/29/30.7 are recognised as control symbols
`timescale 1ns/1ns

module symbol_decoder (
    input  logic             WCLK,
    input  logic             RESET_WCLK,
    input  rx_pkg::rx_sym_t  sym,
    output rx_pkg::rx_byte_t dec
);

    logic       rd;          // 1 = positive
    logic       rd_mid;      // disparity after the 6b block
    logic       rd_next;
    logic [5:0] s6;          // abcdei
    logic [3:0] s4;          // fghj
    logic [3:0] s4_lut;
    logic [4:0] d5;
    logic [2:0] d3;
    logic       err6;
    logic       err4;
    logic       k_sym;
    logic       code_err;
    logic       disp_err;
    int         ones6;
    int         ones4;

    always_comb begin
        s6    = sym.code[9:4];
        s4    = sym.code[3:0];
        ones6 = $countones(s6);
        ones4 = $countones(s4);
        // K28 with rd+ sends the neutral 4b codes inverted
        s4_lut = (s6 == 6'b110000) ? ~s4 : s4;

        err6 = 1'b0;
        case (s6)
            6'b100111, 6'b011000: d5 = 5'd0;
            6'b011101, 6'b100010: d5 = 5'd1;
            6'b101101, 6'b010010: d5 = 5'd2;
            6'b110001:            d5 = 5'd3;
            6'b110101, 6'b001010: d5 = 5'd4;
            6'b101001:            d5 = 5'd5;
            6'b011001:            d5 = 5'd6;
            6'b111000, 6'b000111: d5 = 5'd7;
            6'b111001, 6'b000110: d5 = 5'd8;
            6'b100101:            d5 = 5'd9;
            6'b010101:            d5 = 5'd10;
            6'b110100:            d5 = 5'd11;
            6'b001101:            d5 = 5'd12;
            6'b101100:            d5 = 5'd13;
            6'b011100:            d5 = 5'd14;
            6'b010111, 6'b101000: d5 = 5'd15;
            6'b011011, 6'b100100: d5 = 5'd16;
            6'b100011:            d5 = 5'd17;
            6'b010011:            d5 = 5'd18;
            6'b110010:            d5 = 5'd19;
            6'b001011:            d5 = 5'd20;
            6'b101010:            d5 = 5'd21;
            6'b011010:            d5 = 5'd22;
            6'b111010, 6'b000101: d5 = 5'd23;
            6'b110011, 6'b001100: d5 = 5'd24;
            6'b100110:            d5 = 5'd25;
            6'b010110:            d5 = 5'd26;
            6'b110110, 6'b001001: d5 = 5'd27;
            6'b001110:            d5 = 5'd28;
            6'b101110, 6'b010001: d5 = 5'd29;
            6'b011110, 6'b100001: d5 = 5'd30;
            6'b101011, 6'b010100: d5 = 5'd31;
            6'b001111, 6'b110000: d5 = 5'd28;  // K28
            default: begin
                d5   = 5'd0;
                err6 = 1'b1;
            end
        endcase

        err4 = 1'b0;
        case (s4_lut)
            4'b1011, 4'b0100:                   d3 = 3'd0;
            4'b1001:                            d3 = 3'd1;
            4'b0101:                            d3 = 3'd2;
            4'b1100, 4'b0011:                   d3 = 3'd3;
            4'b1101, 4'b0010:                   d3 = 3'd4;
            4'b1010:                            d3 = 3'd5;
            4'b0110:                            d3 = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: d3 = 3'd7;  // primary and alternate
            default: begin
                d3   = 3'd0;
                err4 = 1'b1;
            end
        endcase

        k_sym = (s6 == 6'b001111) || (s6 == 6'b110000) ||
                (((s4 == 4'b0111) || (s4 == 4'b1000)) && (d5 inside {23, 27, 29, 30}));
        code_err = err6 || err4;

        // 111000 and 000111 are neutral but tied to one disparity, same for 1100/0011
        rd_mid  = (ones6 > 3) ? 1'b1 : (ones6 < 3) ? 1'b0 : rd;
        rd_next = (ones4 > 2) ? 1'b1 : (ones4 < 2) ? 1'b0 : rd_mid;
        disp_err = ((ones6 > 3) && rd) || ((ones6 < 3) && !rd) ||
                   ((s6 == 6'b000111) && !rd) || ((s6 == 6'b111000) && rd) ||
                   ((ones4 > 2) && rd_mid) || ((ones4 < 2) && !rd_mid) ||
                   ((s4 == 4'b0011) && !rd_mid) || ((s4 == 4'b1100) && rd_mid);
    end

    always_ff @(posedge WCLK) begin
        dec.k    <= k_sym;
        dec.err  <= code_err || disp_err;
        dec.data <= {d3, d5};
        if (RESET_WCLK) begin
            dec.valid <= 1'b0;
            rd        <= 1'b0;
        end else begin
            dec.valid <= sym.valid;
            if (sym.valid && !code_err) begin
                rd <= rd_next;     // invalid code tells nothing about disparity
            end
        end
    end

    // an accepted symbol is never more than two bits off balance
    a_dec_balance: assert property (
        @(posedge WCLK) disable iff (RESET_WCLK)
        sym.valid && !code_err && !disp_err |-> (ones6 + ones4) inside {4, 5, 6}
    );

endmodule

//--- verilog/word_fifo.sv
// synchronous first-word-fall-through FIFO, rdata is valid while not empty
// depth must be a power of two and at most 16 for the 5-bit count
`timescale 1ns/1ns
`include "rx_macros.svh"

module word_fifo (
    input  logic             WCLK,
    input  logic             RESET_WCLK,
    input  logic             push,
    input  rx_pkg::rx_word_t wdata,
    input  logic             pop,
    output rx_pkg::rx_word_t rdata,
    output logic             empty,
    output logic             full,
    output logic [4:0]       count
);
    import rx_pkg::*;

    localparam int AW = $clog2(`RX_FIFO_DEPTH);

    rx_word_t        mem [`RX_FIFO_DEPTH];
    logic [AW-1:0]   wptr;
    logic [AW-1:0]   rptr;
    logic            do_push;
    logic            do_pop;

    assign empty   = (count == 5'd0);
    assign full    = (count == 5'(`RX_FIFO_DEPTH));
    assign do_push = push && !full;     // overflow is dropped
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rptr];

    always_ff @(posedge WCLK) begin
        if (do_push) begin
            mem[wptr] <= wdata;
        end
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= 5'd0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 5'd1;
                2'b01:   count <= count - 5'd1;
                default: count <= count;
            endcase
        end
    end

    // the register slave only pops a non-empty FIFO
    a_no_pop_empty: assert property (
        @(posedge WCLK) disable iff (RESET_WCLK)
        !(pop && empty)
    );

    a_count_max: assert property (
        @(posedge WCLK) disable iff (RESET_WCLK)
        count <= 5'(`RX_FIFO_DEPTH)
    );

endmodule

//--- verilog/word_packer.sv
// packs three data bytes into one word, a K or bad symbol restarts packing
// both counters saturate at 255 and are zeroed by clear
`timescale 1ns/1ns

module word_packer (
    input  logic             WCLK,
    input  logic             RESET_WCLK,
    input  rx_pkg::rx_byte_t dec,
    input  logic             fifo_full,
    input  logic             clear,
    output logic             push,
    output rx_pkg::rx_word_t word,
    output logic [7:0]       dec_err_cnt,
    output logic [7:0]       lost_cnt
);

    logic [1:0] idx;        // next byte slot
    logic       data_byte;

    assign data_byte = dec.valid && !dec.err && !dec.k;

    always_ff @(posedge WCLK) begin
        if (data_byte) begin
            case (idx)
                2'd0:    word.b0 <= dec.data;
                2'd1:    word.b1 <= dec.data;
                default: word.b2 <= dec.data;
            endcase
        end
    end

    always_ff @(posedge WCLK) begin
        if (RESET_WCLK) begin
            idx         <= 2'd0;
            push        <= 1'b0;
            dec_err_cnt <= 8'd0;
            lost_cnt    <= 8'd0;
        end else begin
            push <= data_byte && (idx == 2'd2);
            if (dec.valid) begin
                if (!data_byte || idx == 2'd2) begin
                    idx <= 2'd0;    // partial word dropped on K or error
                end else begin
                    idx <= idx + 2'd1;
                end
            end
            if (clear) begin
                dec_err_cnt <= 8'd0;
            end else if (dec.valid && dec.err && dec_err_cnt != 8'hff) begin
                dec_err_cnt <= dec_err_cnt + 8'd1;
            end
            if (clear) begin
                lost_cnt <= 8'd0;
            end else if (push && fifo_full && lost_cnt != 8'hff) begin
                lost_cnt <= lost_cnt + 8'd1;   // fifo drops this one
            end
        end
    end

    a_idx_range: assert property (
        @(posedge WCLK) disable iff (RESET_WCLK)
        idx <= 2'd2
    );

endmodule
